//--- common/psg_macros.svh
`ifndef PSG_MACROS_SVH
`define PSG_MACROS_SVH

// channel count and index width
`define PSG_CHANS 8
`define PSG_CHAN_W 3

// signed sample width
`define SAMPLE_W 12

// wave table is 1024 words
`define WAVE_AW 10

// phase accumulator, top 8 bits are the table index
`define PHASE_W 24

// mixer output, wide enough for eight full-scale samples
`define MIX_W 15

// wave memory read latency in clocks
`define WAVE_LAT 2

`endif

//--- common/psgPkg.sv
`default_nettype none

`include "psg_macros.svh"

package psgPkg;

	// ==================================================
	// host register selectors
	// ==================================================
	// REG_FREQ  phase increment, full data word
	// REG_BASE  wave base address, data[WAVE_AW-1:0]
	// REG_CTRL  channel enable in data[0]
	// REG_WAVE  table word write, address in data[23:14], sample in data[11:0]
	typedef enum logic [1:0] {
		REG_FREQ,
		REG_BASE,
		REG_CTRL,
		REG_WAVE
	} psgReg_e;

	// one host write, data is as wide as a phase increment
	typedef struct packed {
		logic                   we;
		logic [`PSG_CHAN_W-1:0] chan;
		psgReg_e                regSel;
		logic [`PHASE_W-1:0]    data;
	} hostWr_t;

	// channel fetch request, req is a level held until served
	typedef struct packed {
		logic                req;
		logic [`WAVE_AW-1:0] addr;
	} fetchReq_t;

	// read result broadcast to all channels
	typedef struct packed {
		logic                        valid;
		logic [`PSG_CHAN_W-1:0]      chan;
		logic signed [`SAMPLE_W-1:0] data;
	} sampleResp_t;

	// channel fetch FSM
	typedef enum logic {
		CH_IDLE,
		CH_WAIT
	} chanState_e;

endpackage

`default_nettype wire

//--- channel/psgChannel.sv
`timescale 1ns/100ps
`default_nettype none

`include "psg_macros.svh"

module psgChannel #(
	parameter logic [`PSG_CHAN_W-1:0] CHAN_ID = '0
) (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        ce,
	input  psgPkg::hostWr_t             hostWr,
	input  psgPkg::sampleResp_t         resp,
	output psgPkg::fetchReq_t           fetch,
	output logic signed [`SAMPLE_W-1:0] sample,
	output logic                        enabled
);
	import psgPkg::*;

	localparam int IDX_W = 8;

	logic [`PHASE_W-1:0] freq;
	logic [`WAVE_AW-1:0] base;
	logic [`PHASE_W-1:0] phase;
	logic [IDX_W-1:0]    index;
	logic [IDX_W-1:0]    lastIndex;
	chanState_e          state;
	logic                reqQ;
	logic [`WAVE_AW-1:0] addrQ;
	logic                hostHit;
	logic                startFetch;
	logic                ownResp;

	assign index = phase[`PHASE_W-1 -: IDX_W];
	assign hostHit = hostWr.we && (hostWr.chan == CHAN_ID);
	assign ownResp = resp.valid && (resp.chan == CHAN_ID);
	// a new table index while idle starts a fetch
	assign startFetch = enabled && (state == CH_IDLE) && (index != lastIndex);

	always_ff @(posedge clk) begin
		if (rst) begin
			freq <= '0;
			base <= '0;
			enabled <= 1'b0;
		end else if (hostHit) begin
			case (hostWr.regSel)
				REG_FREQ: freq <= hostWr.data;
				REG_BASE: base <= hostWr.data[`WAVE_AW-1:0];
				REG_CTRL: enabled <= hostWr.data[0];
				default: ;
			endcase
		end
	end

	// phase keeps running while a fetch is pending
	always_ff @(posedge clk) begin
		if (rst) begin
			phase <= '0;
		end else if (ce && enabled) begin
			phase <= phase + freq;
		end
	end

	// ==================================================
	// fetch FSM
	// ==================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= CH_IDLE;
			reqQ <= 1'b0;
			lastIndex <= '0;
			sample <= '0;
		end else if (!enabled) begin
			// disabled channel goes quiet and withdraws its request
			state <= CH_IDLE;
			reqQ <= 1'b0;
			sample <= '0;
		end else begin
			case (state)
				CH_IDLE: begin
					if (startFetch) begin
						state <= CH_WAIT;
						reqQ <= 1'b1;
						lastIndex <= index;
					end
				end
				CH_WAIT: begin
					if (ownResp) begin
						state <= CH_IDLE;
						reqQ <= 1'b0;
						sample <= resp.data;
					end
				end
				default: state <= CH_IDLE;
			endcase
		end
	end

	// wraps modulo the table size
	always_ff @(posedge clk) begin
		if (startFetch) begin
			addrQ <= base + `WAVE_AW'(index);
		end
	end

	assign fetch.req = reqQ;
	assign fetch.addr = addrQ;

endmodule

`default_nettype wire

//--- design/psgBusArb.sv
`timescale 1ns/100ps
`default_nettype none

`include "psg_macros.svh"

module psgBusArb (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   ce,
	input  logic                   ack,
	input  logic [`PSG_CHANS-1:0]  req,
	output logic [`PSG_CHANS-1:0]  busGrant,
	output logic [`PSG_CHAN_W-1:0] busOwner
);
	logic [`PSG_CHAN_W-1:0] nextOwner;
	logic                   anyReq;

	// fixed priority, scan from the top so index 0 lands last and wins
	always_comb begin
		nextOwner = '0;
		for (int i = `PSG_CHANS - 1; i >= 0; i--) begin
			if (req[i]) begin
				nextOwner = `PSG_CHAN_W'(i);
			end
		end
	end

	assign anyReq = |req;

	// grant and owner move together, only while the memory is idle
	always_ff @(posedge clk) begin
		if (rst) begin
			busGrant <= '0;
			busOwner <= '0;
		end else if (ce && ack && anyReq) begin
			busGrant <= {{(`PSG_CHANS - 1){1'b0}}, 1'b1} << nextOwner;
			busOwner <= nextOwner;
		end
		// no requester, last owner keeps the bus
	end

endmodule

`default_nettype wire

//--- design/psgWaveMem.sv
`timescale 1ns/100ps
`default_nettype none

`include "psg_macros.svh"

module psgWaveMem (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   ce,
	input  psgPkg::hostWr_t        hostWr,
	input  logic                   ownerReq,
	input  logic [`WAVE_AW-1:0]    ownerAddr,
	input  logic [`PSG_CHAN_W-1:0] busOwner,
	output logic                   ack,
	output psgPkg::sampleResp_t    resp
);
	import psgPkg::*;

	localparam int CNT_W = $clog2(`WAVE_LAT + 1);

	logic signed [`SAMPLE_W-1:0] mem [1 << `WAVE_AW];
	logic [`WAVE_AW-1:0]         rdAddr;
	logic [`PSG_CHAN_W-1:0]      rdOwner;
	logic signed [`SAMPLE_W-1:0] rdData;
	logic                        busy;
	logic [CNT_W-1:0]            cnt;
	logic                        fire;
	logic                        respValid;
	logic [`PSG_CHAN_W-1:0]      respChan;
	logic signed [`SAMPLE_W-1:0] respData;

	// host write port and registered read port
	always_ff @(posedge clk) begin
		if (hostWr.we && hostWr.regSel == REG_WAVE) begin
			mem[hostWr.data[`PHASE_W-1 -: `WAVE_AW]] <= hostWr.data[`SAMPLE_W-1:0];
		end
		rdData <= mem[rdAddr];
	end

	// ==================================================
	// one outstanding read
	// ==================================================
	assign fire = busy && !respValid && (cnt == '0);

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			cnt <= '0;
			respValid <= 1'b0;
		end else begin
			respValid <= fire;
			if (!busy) begin
				if (ce && ownerReq) begin
					busy <= 1'b1;
					cnt <= CNT_W'(`WAVE_LAT);
				end
			end else if (respValid) begin
				// back to idle the clock after the response pulse
				busy <= 1'b0;
			end else if (cnt != '0) begin
				cnt <= cnt - 1'b1;
			end
		end
	end

	// owner latched at start, so a regrant cannot disturb the read
	always_ff @(posedge clk) begin
		if (!busy && ce && ownerReq) begin
			rdAddr <= ownerAddr;
			rdOwner <= busOwner;
		end
		if (fire) begin
			respChan <= rdOwner;
			respData <= rdData;
		end
	end

	assign ack = !busy;
	assign resp.valid = respValid;
	assign resp.chan = respChan;
	assign resp.data = respData;

endmodule

`default_nettype wire

//--- design/psgMixer.sv
`timescale 1ns/100ps
`default_nettype none

`include "psg_macros.svh"

module psgMixer (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        ce,
	input  logic signed [`SAMPLE_W-1:0] samples [`PSG_CHANS],
	input  logic [`PSG_CHANS-1:0]       enabled,
	output logic signed [`MIX_W-1:0]    audioOut,
	output logic                        audioValid
);
	logic signed [`MIX_W-1:0] mixSum;

	// signed operands in a MIX_W context, so each sample is sign-extended
	always_comb begin
		mixSum = '0;
		for (int i = 0; i < `PSG_CHANS; i++) begin
			if (enabled[i]) begin
				mixSum = mixSum + samples[i];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			audioValid <= 1'b0;
		end else begin
			audioValid <= ce;
		end
	end

	always_ff @(posedge clk) begin
		if (ce) begin
			audioOut <= mixSum;
		end
	end

endmodule

`default_nettype wire

//--- design/psgTop.sv
`timescale 1ns/100ps
`default_nettype none

`include "psg_macros.svh"

module psgTop (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     ce,
	input  psgPkg::hostWr_t          hostWr,
	output logic signed [`MIX_W-1:0] audioOut,
	output logic                     audioValid,
	output logic [`PSG_CHANS-1:0]    busGrant,
	output logic [`PSG_CHAN_W-1:0]   busOwner
);
	import psgPkg::*;

	fetchReq_t                   chFetch [`PSG_CHANS];
	logic [`PSG_CHANS-1:0]       chReq;
	logic signed [`SAMPLE_W-1:0] chSample [`PSG_CHANS];
	logic [`PSG_CHANS-1:0]       chEnabled;
	sampleResp_t                 resp;
	logic                        ack;
	logic                        ownerReq;
	logic [`WAVE_AW-1:0]         ownerAddr;

	// ==================================================
	// channels
	// ==================================================
	for (genvar g = 0; g < `PSG_CHANS; g++) begin : genChan
		psgChannel #(
			.CHAN_ID(`PSG_CHAN_W'(g))
		) psgChannel_inst (
			.clk    (clk),
			.rst    (rst),
			.ce     (ce),
			.hostWr (hostWr),
			.resp   (resp),
			.fetch  (chFetch[g]),
			.sample (chSample[g]),
			.enabled(chEnabled[g])
		);

		assign chReq[g] = chFetch[g].req;
	end

	psgBusArb psgBusArb_inst (
		.clk     (clk),
		.rst     (rst),
		.ce      (ce),
		.ack     (ack),
		.req     (chReq),
		.busGrant(busGrant),
		.busOwner(busOwner)
	);

	// memory sees only the current owner's request
	assign ownerReq = chReq[busOwner];
	assign ownerAddr = chFetch[busOwner].addr;

	psgWaveMem psgWaveMem_inst (
		.clk      (clk),
		.rst      (rst),
		.ce       (ce),
		.hostWr   (hostWr),
		.ownerReq (ownerReq),
		.ownerAddr(ownerAddr),
		.busOwner (busOwner),
		.ack      (ack),
		.resp     (resp)
	);

	psgMixer psgMixer_inst (
		.clk       (clk),
		.rst       (rst),
		.ce        (ce),
		.samples   (chSample),
		.enabled   (chEnabled),
		.audioOut  (audioOut),
		.audioValid(audioValid)
	);

endmodule

`default_nettype wire

//--- verif/psgClkGen.sv
`timescale 1ns/100ps
`default_nettype none

module psgClkGen #(
	parameter real PERIOD = 10.0,
	parameter int  RESET_CYCLES = 3
) (
	output logic clk,
	output logic rst
);
	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2.0) clk = ~clk;
	end

	// reset held for the first few rising edges
	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

`default_nettype wire

//--- verif/psgTb.sv
`timescale 1ns/100ps
`default_nettype none

`include "psg_macros.svh"

module psgTb;
	import psgPkg::*;

	localparam int GRANT_LIMIT = 200;
	localparam int SAMPLE_CH = 2;
	localparam int MIX_CH = 4;
	localparam int IDLE_CH = 5;
	localparam logic signed [`SAMPLE_W-1:0] CONST_A = 12'sh2a5;
	localparam logic signed [`SAMPLE_W-1:0] CONST_B = -12'sd237;
	localparam logic [`WAVE_AW-1:0] BASE_A = 10'd256;
	localparam logic [`WAVE_AW-1:0] BASE_B = 10'd512;
	// table index moves once every four ce
	localparam logic [`PHASE_W-1:0] SLOW_FREQ = 24'h004000;

	logic                     clk;
	logic                     rst;
	logic                     ce = 1'b0;
	hostWr_t                  hostWr;
	logic signed [`MIX_W-1:0] audioOut;
	logic                     audioValid;
	logic [`PSG_CHANS-1:0]    busGrant;
	logic [`PSG_CHAN_W-1:0]   busOwner;

	logic                     ceRun = 1'b0;
	logic [1:0]               ceCnt = '0;
	logic                     resetCheck = 1'b1;
	logic                     prioCheck = 1'b0;
	logic                     sumCheck = 1'b0;
	logic [`PSG_CHANS-1:0]    enMask = '0;
	logic signed [`MIX_W-1:0] expSum = '0;
	int                       errors = 0;
	int                       grantErrors = 0;
	int                       markErrors = 0;
	int                       testsRun = 0;
	int                       testsFailed = 0;
	integer                   seed = 32'h4da5;

	psgClkGen psgClkGen_inst (
		.clk(clk),
		.rst(rst)
	);

	psgTop psgTop_inst (
		.clk       (clk),
		.rst       (rst),
		.ce        (ce),
		.hostWr    (hostWr),
		.audioOut  (audioOut),
		.audioValid(audioValid),
		.busGrant  (busGrant),
		.busOwner  (busOwner)
	);

	// ce pulses every fourth clock while running
	always @(posedge clk) begin
		if (rst || !ceRun) begin
			ceCnt <= '0;
			ce <= 1'b0;
		end else begin
			ceCnt <= ceCnt + 1'b1;
			ce <= (ceCnt == 2'd3);
		end
	end

	task automatic reportMismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		errors++;
		$display("CHECK FAILED %s got %h expected %h at %0t", name, got, exp, $time);
	endtask

	task automatic reportValue(input string name, input logic [31:0] value, input string rule);
		errors++;
		grantErrors++;
		$display("CHECK FAILED %s = %h %s at %0t", name, value, rule, $time);
	endtask

	// ==================================================
	// properties
	// ==================================================
	resetState: assert property (@(posedge clk) disable iff (rst)
		resetCheck |-> {busGrant, busOwner, audioValid} == '0)
		else reportMismatch("{busGrant,busOwner,audioValid}",
			$sampled({busGrant, busOwner, audioValid}), 0);

	grantOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(busGrant))
		else reportValue("busGrant", $sampled(busGrant), "is not one-hot");

	grantOwner: assert property (@(posedge clk) disable iff (rst)
		busGrant != '0 |-> busGrant == (`PSG_CHANS'(1) << busOwner))
		else reportValue("busGrant", $sampled(busGrant),
			$sformatf("disagrees with busOwner %h", $sampled(busOwner)));

	grantTiming: assert property (@(posedge clk) disable iff (rst)
		!$stable(busGrant) |-> $past(ce))
		else reportValue("busGrant", $sampled(busGrant), "changed without a ce cycle");

	grantEnabled: assert property (@(posedge clk) disable iff (rst)
		!$stable(busGrant) |-> (busGrant & enMask) != '0)
		else reportValue("busGrant", $sampled(busGrant), "moved to a disabled channel");

	idleNeverGranted: assert property (@(posedge clk) disable iff (rst) !busGrant[IDLE_CH])
		else reportValue("busGrant", $sampled(busGrant), "granted the idle channel");

	firstGrant: assert property (@(posedge clk) disable iff (rst)
		prioCheck && $past(busGrant) == '0 && busGrant != '0 |-> busGrant == `PSG_CHANS'(1))
		else reportMismatch("busGrant", $sampled(busGrant), 1);

	mixSum: assert property (@(posedge clk) disable iff (rst)
		sumCheck && audioValid |-> audioOut == expSum)
		else reportMismatch("audioOut", $sampled(audioOut), expSum);

	// ==================================================
	// stimulus helpers
	// ==================================================
	task automatic hostWrite(input psgReg_e sel, input int chan, input logic [`PHASE_W-1:0] data);
		@(posedge clk);
		hostWr.we <= 1'b1;
		hostWr.chan <= `PSG_CHAN_W'(chan);
		hostWr.regSel <= sel;
		hostWr.data <= data;
		@(posedge clk);
		hostWr.we <= 1'b0;
	endtask

	task automatic fillRegion(input logic [`WAVE_AW-1:0] base, input logic [11:0] value);
		for (int i = 0; i < 256; i++) begin
			hostWrite(REG_WAVE, 0, {base + `WAVE_AW'(i), 2'b00, value});
		end
	endtask

	task automatic configure(input int chan, input logic [`WAVE_AW-1:0] base,
			input logic [`PHASE_W-1:0] freq);
		hostWrite(REG_BASE, chan, `PHASE_W'(base));
		hostWrite(REG_FREQ, chan, freq);
	endtask

	task automatic setEnable(input int chan, input logic on);
		enMask[chan] = on;
		hostWrite(REG_CTRL, chan, `PHASE_W'(on));
	endtask

	task automatic waitClocks(input int count);
		repeat (count) @(posedge clk);
	endtask

	task automatic waitGrant(input int chan);
		int n;
		n = 0;
		while (busGrant != (`PSG_CHANS'(1) << chan) && n < GRANT_LIMIT) begin
			@(posedge clk);
			n++;
		end
		if (busGrant != (`PSG_CHANS'(1) << chan)) begin
			errors++;
			$display("timeout: channel %0d was not granted within %0d clocks", chan, n);
		end
	endtask

	task automatic waitValids(input int count);
		int seen;
		int n;
		seen = 0;
		n = 0;
		while (seen < count && n < count * 8 + 16) begin
			@(posedge clk);
			if (audioValid) begin
				seen++;
			end
			n++;
		end
		if (seen < count) begin
			errors++;
			$display("timeout: saw only %0d of %0d audioValid pulses", seen, count);
		end
	endtask

	task automatic endTest(input string name, input int failures);
		testsRun++;
		if (failures != 0) begin
			testsFailed++;
		end
		$display("test %0d %s: %s", testsRun, name, (failures == 0) ? "ok" : "failed");
		markErrors = errors;
	endtask

	// ==================================================
	// test sequence
	// ==================================================
	initial begin
		int n;
		hostWr = '0;
		n = 0;
		while (rst && n < 20) begin
			@(posedge clk);
			n++;
		end
		if (rst) begin
			errors++;
			$display("timeout: reset was never released");
		end

		// whole table gets a pattern, then two constant regions
		for (int a = 0; a < (1 << `WAVE_AW); a++) begin
			hostWrite(REG_WAVE, 0, {`WAVE_AW'(a), 2'b00, {2'(a), `WAVE_AW'(a)} ^ 12'h9c3});
		end
		fillRegion(BASE_A, CONST_A);
		fillRegion(BASE_B, CONST_B);
		resetCheck = 1'b0;
		endTest("reset state", errors - markErrors);

		// 0 and 7 start together, 0 must win first
		configure(0, 0, SLOW_FREQ);
		configure(7, 0, SLOW_FREQ);
		configure(IDLE_CH, BASE_B, SLOW_FREQ);
		prioCheck = 1'b1;
		setEnable(0, 1'b1);
		setEnable(7, 1'b1);
		ceRun <= 1'b1;
		waitGrant(7);
		prioCheck = 1'b0;
		ceRun <= 1'b0;
		waitClocks(8);
		setEnable(0, 1'b0);
		setEnable(7, 1'b0);
		endTest("priority", errors - markErrors);

		configure(SAMPLE_CH, BASE_A, SLOW_FREQ);
		setEnable(SAMPLE_CH, 1'b1);
		expSum = CONST_A;
		ceRun <= 1'b1;
		waitGrant(SAMPLE_CH);
		waitValids(4);
		sumCheck = 1'b1;
		waitValids(16);
		endTest("sample path", errors - markErrors);

		sumCheck = 1'b0;
		configure(MIX_CH, BASE_B, SLOW_FREQ);
		setEnable(MIX_CH, 1'b1);
		expSum = CONST_A + CONST_B;
		waitGrant(MIX_CH);
		waitValids(4);
		sumCheck = 1'b1;
		waitValids(16);
		for (int i = 0; i < 3; i++) begin
			hostWrite(REG_FREQ, SAMPLE_CH, 24'h001000 + (24'($random(seed)) & 24'h03ffff));
			hostWrite(REG_FREQ, MIX_CH, 24'h001000 + (24'($random(seed)) & 24'h03ffff));
			waitValids(12);
		end
		endTest("mixing", errors - markErrors);

		// ce stopped so the grant cannot move while the mask changes
		sumCheck = 1'b0;
		ceRun <= 1'b0;
		waitClocks(8);
		setEnable(MIX_CH, 1'b0);
		expSum = CONST_A;
		ceRun <= 1'b1;
		sumCheck = 1'b1;
		waitValids(16);
		sumCheck = 1'b0;
		endTest("disabled channel", errors - markErrors);

		endTest("grant rules", grantErrors);
		$display("%0d tests, %0d failed, %0d errors", testsRun, testsFailed, errors);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- psgTop.f
+incdir+common
common/psgPkg.sv
channel/psgChannel.sv
design/psgBusArb.sv
design/psgWaveMem.sv
design/psgMixer.sv
design/psgTop.sv
verif/psgClkGen.sv
verif/psgTb.sv

//--- Bender.yml
package:
  name: psg

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/psgPkg.sv
      - channel/psgChannel.sv
      - design/psgBusArb.sv
      - design/psgWaveMem.sv
      - design/psgMixer.sv
      - design/psgTop.sv
  - target: test
    include_dirs:
      - common
    files:
      - verif/psgClkGen.sv
      - verif/psgTb.sv
